/* Makefile */
# Verilator build and run of the matrix-multiply unit testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module mxu_tb -Mdir obj_dir -o mxu_sim
	-./obj_dir/mxu_sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'All tests passed!' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* project.f */
+incdir+verilog
verilog/mxu_pkg.sv
verilog/mxu_pe.sv
verilog/mxu_tile.sv
verilog/mxu_wb_regs.sv
verilog/mxu_collector.sv
verilog/mxu_top.sv
verif/mxu_properties.sv
verif/mxu_clkgen.sv
verif/mxu_tb.sv

/* verif/mxu_clkgen.sv */
// clock generator with a 10 ns period and an active-low reset held for eight cycles
`timescale 1ns/1ps

module mxu_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 100 MHz
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released between sampling edges
    end

endmodule

/* verif/mxu_properties.sv */
// concurrent checks on the wishbone handshake and the result queue fill level
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  cyc,
    input logic                  stb,
    input logic                  ack,
    input logic [`MXU_CNT_W-1:0] q_count   // internal to the top level
);

    int unsigned fail_count = 0; // failed assertion attempts, read by the testbench

    // ack answers a request present on the edge before it rose
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(cyc && stb)
    ) else begin
        fail_count++;
        $error("ack rose without cyc and stb on the previous edge");
    end

    // single-cycle ack of the classic handshake
    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |=> !ack
    ) else begin
        fail_count++;
        $error("ack stayed high for two cycles");
    end

    // credit at the bus keeps the queue within its depth
    a_queue_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        q_count <= `MXU_Q_DEPTH
    ) else begin
        fail_count++;
        $error("result queue count went above its depth");
    end

endmodule

bind mxu_top mxu_properties u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .cyc    (cyc),
    .stb    (stb),
    .ack    (ack),
    .q_count(q_count)
);

/* verif/mxu_tb.sv */
// testbench with bus tasks, lfsr stimulus, reference model, read checks and a run limit
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_tb;

    localparam int MAX_CYCLES = 4000; // well above the length of the whole sequence

    logic                  clk;
    logic                  rst_n;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`MXU_ADR_W-1:0] adr;
    logic [31:0]           dat_w;
    logic [31:0]           dat_r;
    logic                  ack;

    logic [31:0] lfsr;                // fibonacci with taps 32 22 2 1
    logic [31:0] wrow [`MXU_ROWS];    // model weight rows with lane c for column c
    logic [31:0] exp_q [$];           // expected columns in groups of four per vector
    int          cycles = 0;

    mxu_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    mxu_top u_dut (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (u_dut.u_props.fail_count != 0) begin
            $display("ERROR a bound bus or queue assertion failed");
            $display("Test failures found");
            $fatal(1, "bound property failed");
        end else if (cycles >= MAX_CYCLES) begin
            $display("ERROR run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "run limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "read data mismatch");
        end
    endtask

    // one lfsr step per bit of the word
    function automatic logic [31:0] rand_word();
        logic        fb;
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w    = {w[30:0], fb};
        end
        return w;
    endfunction

    // starts at a falling edge and returns at the one where ack is seen
    task automatic write_word(input logic [`MXU_ADR_W-1:0] a, input logic [31:0] d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        @(negedge clk);
        while (!ack) @(negedge clk); // held off writes wait here
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic read_word(input logic [`MXU_ADR_W-1:0] a, output logic [31:0] d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack) @(negedge clk);
        d   = dat_r; // valid through the ack cycle
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wait_status(input int n);
        logic [31:0] s;
        s = '1;
        while (s != 32'(n)) read_word(`MXU_ADDR_STATUS, s);
    endtask

    // y[c] = sum over rows of x[r] * w[r][c] on signed bytes
    function automatic logic [31:0] model_col(input logic [31:0] x, input int c);
        int                acc;
        logic signed [7:0] xa;
        logic signed [7:0] wb;
        acc = 0;
        for (int r = 0; r < `MXU_ROWS; r++) begin
            xa  = x[8*r +: 8];
            wb  = wrow[r][8*c +: 8];
            acc = acc + int'(xa) * int'(wb);
        end
        return acc;
    endfunction

    // four new rows with the newest ending in row 0
    task automatic load_weights();
        logic [31:0] w;
        for (int k = 0; k < `MXU_ROWS; k++) begin
            w = rand_word();
            for (int r = `MXU_ROWS - 1; r > 0; r--) wrow[r] = wrow[r-1];
            wrow[0] = w;
            write_word(`MXU_ADDR_WEIGHT, w);
        end
    endtask

    task automatic push_vector(input logic [31:0] x);
        for (int c = 0; c < `MXU_COLS; c++) exp_q.push_back(model_col(x, c));
        write_word(`MXU_ADDR_ACT, x);
    endtask

    // waits for a queued result and checks all columns while column 3 pops it
    task automatic pop_result();
        logic [31:0] s;
        logic [31:0] v;
        s = '0;
        while (s == '0) read_word(`MXU_ADDR_STATUS, s);
        for (int c = 0; c < `MXU_COLS; c++) begin
            read_word(4'(`MXU_ADDR_RES + c), v);
            check_value($sformatf("dat_r result column %0d", c), v, exp_q.pop_front());
        end
    endtask

    // requests an activation write with the queue full and then withdraws it
    task automatic check_held_off(input logic [31:0] x);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = `MXU_ADDR_ACT;
        dat_w = x;
        repeat (12) begin
            @(negedge clk);
            assert (!ack) else begin
                $display("ERROR activation write was acknowledged with no room in the queue");
                $display("Test failures found");
                $fatal(1, "missing back-pressure");
            end
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    initial begin
        logic [31:0] x;
        logic [31:0] v;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        lfsr  = 32'hdb281d31;
        for (int r = 0; r < `MXU_ROWS; r++) wrow[r] = '0; // weights reset to zero
        @(posedge rst_n);
        @(negedge clk);

        // empty queue after reset reads zero everywhere
        read_word(`MXU_ADDR_STATUS, v);
        check_value("dat_r status", v, 32'h0);
        for (int c = 0; c < `MXU_COLS; c++) begin
            read_word(4'(`MXU_ADDR_RES + c), v);
            check_value($sformatf("dat_r empty column %0d", c), v, 32'h0);
        end

        // single product
        load_weights();
        x = rand_word();
        push_vector(x);
        wait_status(1);
        pop_result();

        // four in flight while the fifth and sixth wait for a pop
        for (int k = 0; k < 4; k++) begin
            x = rand_word();
            push_vector(x);
        end
        for (int k = 0; k < 2; k++) begin
            x = rand_word();
            check_held_off(x);
            pop_result();
            push_vector(x);
        end
        repeat (4) pop_result();

        // weight reload between two vectors
        x = rand_word();
        push_vector(x);
        pop_result();
        load_weights();
        x = rand_word();
        push_vector(x);
        pop_result();

        // weight clear gives an all zero result
        write_word(`MXU_ADDR_CTRL, 32'h1);
        for (int r = 0; r < `MXU_ROWS; r++) wrow[r] = '0;
        x = rand_word();
        push_vector(x);
        pop_result();

        // flush of two stored results before more traffic
        load_weights();
        repeat (2) begin
            x = rand_word();
            push_vector(x);
        end
        wait_status(2);
        write_word(`MXU_ADDR_CTRL, 32'h2);
        exp_q.delete();
        read_word(`MXU_ADDR_STATUS, v);
        check_value("dat_r status after flush", v, 32'h0);
        read_word(`MXU_ADDR_RES, v);
        check_value("dat_r column 0 after flush", v, 32'h0);
        x = rand_word();
        push_vector(x);
        pop_result();

        if (u_dut.u_props.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "bound property failed");
        end
    end

endmodule

/* verilog/mxu_collector.sv */
// column deskew for both tiles, result assembly and four-entry result queue
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_collector (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mxu_pkg::mxu_tile_out_t tile0,      // columns 0 and 1
    input  mxu_pkg::mxu_tile_out_t tile1,      // columns 2 and 3
    input  logic                   q_flush,
    input  logic                   res_pop,
    output logic [`MXU_CNT_W-1:0]  q_count,
    output mxu_pkg::mxu_result_t   q_head,     // oldest entry
    output logic                   done_pulse  // one vector stored
);

    localparam int PTR_W = $clog2(`MXU_Q_DEPTH);

    logic [1:0]                  c0_v;   // local column 0 of each tile, one cycle late
    logic [1:0][`MXU_ACC_W-1:0]  c0_s;
    mxu_pkg::mxu_result_t        res_in; // aligned columns
    logic                        res_vld;
    mxu_pkg::mxu_result_t        res_r;  // result register ahead of the queue
    logic                        res_rv;
    mxu_pkg::mxu_result_t        mem [`MXU_Q_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic                        do_pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c0_v   <= '0;
            res_rv <= 1'b0;
        end else begin
            c0_v   <= {tile1.valid[0], tile0.valid[0]};
            res_rv <= res_vld;
        end
    end

    always_ff @(posedge clk) begin
        c0_s  <= {tile1.sum[0], tile0.sum[0]};
        res_r <= res_in;
    end

    // every column now carries the same vector
    assign res_in.col[0] = c0_s[0];
    assign res_in.col[1] = tile0.sum[1];
    assign res_in.col[2] = c0_s[1];
    assign res_in.col[3] = tile1.sum[1];
    assign res_vld       = (&c0_v) && tile0.valid[1] && tile1.valid[1];

    // credit at the bus keeps the queue from filling, so every result is stored
    assign done_pulse = res_rv;
    assign do_pop     = res_pop && (q_count != '0);
    assign q_head     = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else if (q_flush) begin // drops everything, a result arriving now too
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (res_rv) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({res_rv, do_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_rv) mem[wr_ptr] <= res_r;
    end

endmodule

/* verilog/mxu_defines.svh */
// array geometry, datapath widths, result queue depth and bus word addresses
`ifndef MXU_DEFINES_SVH
`define MXU_DEFINES_SVH

// array shape
`define MXU_ROWS        4   // rows, one activation lane each
`define MXU_TILE_COLS   2   // columns in one tile
`define MXU_COLS        4   // columns over both tiles

// datapath
`define MXU_ACC_W       18  // column sum, four int8 products fit
`define MXU_Q_DEPTH     4   // result queue entries
`define MXU_CNT_W       3   // holds 0..MXU_Q_DEPTH
`define MXU_ADR_W       4   // wishbone word address bits

// wishbone word addresses
`define MXU_ADDR_WEIGHT 4'd0
`define MXU_ADDR_ACT    4'd1
`define MXU_ADDR_CTRL   4'd2
`define MXU_ADDR_STATUS 4'd3
`define MXU_ADDR_RES    4'd4 // base of four result columns

`endif

/* verilog/mxu_pe.sv */
// multiply-accumulate cell with stationary weight, data and valid pass-through
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_pe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic signed [7:0]            data_in,   // activation from the left
    input  logic                         valid_in,  // travels with data_in
    input  logic signed [`MXU_ACC_W-1:0] sum_in,    // partial sum from above
    input  logic signed [7:0]            w_in,      // weight from the cell above
    input  logic                         w_shift,   // move weights down one row
    input  logic                         w_clear,   // zero the weight
    output logic signed [7:0]            data_out,  // to the cell on the right
    output logic                         valid_out,
    output logic signed [`MXU_ACC_W-1:0] sum_out,   // to the cell below
    output logic signed [7:0]            w_out      // current weight, feeds the row below
);

    logic signed [7:0]            weight; // stationary operand
    logic signed [`MXU_ACC_W-1:0] mac;

    // all operands signed, so both sides extend to the sum width before the multiply
    assign mac   = sum_in + data_in * weight;
    assign w_out = weight;

    // weight register, the whole column shifts together on w_shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight <= '0;
        end else if (w_clear) begin
            weight <= '0;
        end else if (w_shift) begin
            weight <= w_in; // cell above's old value, or the new row at the top
        end
    end

    // valid flag moves right one cell per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // data and sum only move with a valid beat
    always_ff @(posedge clk) begin
        if (valid_in) begin
            data_out <= data_in;
            sum_out  <= mac;
        end
    end

endmodule

/* verilog/mxu_pkg.sv */
// package with byte vector, control word, write word union, row input, tile output and result
`include "mxu_defines.svh"

package mxu_pkg;

    // four int8 lanes, lane 0 in the low byte
    // weight row (lane = column) or activation vector (lane = row)
    typedef struct packed {
        logic [`MXU_ROWS-1:0][7:0] lane; // cast lanes with $signed where used
    } mxu_vec8_t;

    // control word written to MXU_ADDR_CTRL
    typedef struct packed {
        logic [29:0] rsvd;    // reserved, ignored
        logic        flush_q; // bit 1, empty the result queue
        logic        clear_w; // bit 0, zero every stationary weight
    } mxu_ctrl_t;

    // one bus write word, seen either as bytes or as a command
    typedef union packed {
        mxu_vec8_t vec;
        mxu_ctrl_t ctrl;
    } mxu_wdata_u;

    // skewed input of one array row
    typedef struct packed {
        logic signed [7:0] data;
        logic              valid;
    } mxu_row_t;

    // bottom edge of one tile
    typedef struct packed {
        logic [`MXU_TILE_COLS-1:0][`MXU_ACC_W-1:0] sum;   // signed column sums
        logic [`MXU_TILE_COLS-1:0]                 valid; // per column
    } mxu_tile_out_t;

    // one complete result vector
    typedef struct packed {
        logic [`MXU_COLS-1:0][`MXU_ACC_W-1:0] col; // signed, col 0 in the low bits
    } mxu_result_t;

endpackage

/* verilog/mxu_tile.sv */
// four by two tile of cells with weight shift chain and bottom column sums
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_tile (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  mxu_pkg::mxu_row_t [`MXU_ROWS-1:0]     rows,    // skewed activations
    input  logic [`MXU_TILE_COLS-1:0][7:0]        w_row,   // new top weights, signed
    input  logic                                  w_shift,
    input  logic                                  w_clear,
    output mxu_pkg::mxu_tile_out_t                out
);

    // cell outputs, indexed [row][col]
    logic signed [7:0]            dat_o [`MXU_ROWS][`MXU_TILE_COLS];
    logic                         vld_o [`MXU_ROWS][`MXU_TILE_COLS];
    logic signed [`MXU_ACC_W-1:0] sum_o [`MXU_ROWS][`MXU_TILE_COLS];
    logic signed [7:0]            w_o   [`MXU_ROWS][`MXU_TILE_COLS];

    for (genvar r = 0; r < `MXU_ROWS; r++) begin : g_row
        for (genvar j = 0; j < `MXU_TILE_COLS; j++) begin : g_col
            logic signed [7:0]            d_i;
            logic                         v_i;
            logic signed [`MXU_ACC_W-1:0] s_i;
            logic signed [7:0]            w_i;

            if (j == 0) begin : g_left // left edge takes the row input
                assign d_i = rows[r].data;
                assign v_i = rows[r].valid;
            end else begin : g_inner
                assign d_i = dat_o[r][j-1];
                assign v_i = vld_o[r][j-1];
            end

            if (r == 0) begin : g_top // top sums start at zero
                assign s_i = '0;
                assign w_i = w_row[j];
            end else begin : g_below
                assign s_i = sum_o[r-1][j];
                assign w_i = w_o[r-1][j];
            end

            mxu_pe u_pe (
                .clk      (clk),
                .rst_n    (rst_n),
                .data_in  (d_i),
                .valid_in (v_i),
                .sum_in   (s_i),
                .w_in     (w_i),
                .w_shift  (w_shift),
                .w_clear  (w_clear),
                .data_out (dat_o[r][j]),   // unused in the rightmost column
                .valid_out(vld_o[r][j]),
                .sum_out  (sum_o[r][j]),
                .w_out    (w_o[r][j])      // unused in the bottom row
            );
        end
    end

    // bottom row, column j leaves j cycles after column 0
    for (genvar j = 0; j < `MXU_TILE_COLS; j++) begin : g_bottom
        assign out.sum[j]   = sum_o[`MXU_ROWS-1][j];
        assign out.valid[j] = vld_o[`MXU_ROWS-1][j];
    end

endmodule

/* verilog/mxu_top.sv */
// top level with the wishbone slave, two array tiles and the result collector
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [`MXU_ADR_W-1:0] adr,
    input  logic [31:0]           dat_w,
    output logic [31:0]           dat_r,
    output logic                  ack
);

    mxu_pkg::mxu_row_t [`MXU_ROWS-1:0] rows; // shared by both tiles
    mxu_pkg::mxu_vec8_t                w_row;
    logic                              w_shift;
    logic                              w_clear;
    logic                              q_flush;
    logic                              res_pop;
    logic                              done_pulse;
    logic [`MXU_CNT_W-1:0]             q_count;
    mxu_pkg::mxu_result_t              q_head;
    mxu_pkg::mxu_tile_out_t            tile0_out;
    mxu_pkg::mxu_tile_out_t            tile1_out;

    mxu_wb_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .rows(rows), .w_row(w_row), .w_shift(w_shift), .w_clear(w_clear),
        .q_flush(q_flush), .q_count(q_count), .q_head(q_head),
        .res_pop(res_pop), .done_pulse(done_pulse)
    );

    // weight lanes 0-1 go to the left tile, 2-3 to the right
    mxu_tile u_tile0 (
        .clk(clk), .rst_n(rst_n), .rows(rows), .w_row(w_row.lane[1:0]),
        .w_shift(w_shift), .w_clear(w_clear), .out(tile0_out)
    );

    mxu_tile u_tile1 (
        .clk(clk), .rst_n(rst_n), .rows(rows), .w_row(w_row.lane[3:2]),
        .w_shift(w_shift), .w_clear(w_clear), .out(tile1_out)
    );

    mxu_collector u_coll (
        .clk(clk), .rst_n(rst_n), .tile0(tile0_out), .tile1(tile1_out),
        .q_flush(q_flush), .res_pop(res_pop), .q_count(q_count),
        .q_head(q_head), .done_pulse(done_pulse)
    );

endmodule

/* verilog/mxu_wb_regs.sv */
// wishbone classic slave, write decode, activation skew, weight shifts and in-flight credit
`timescale 1ns/1ps
`include "mxu_defines.svh"

module mxu_wb_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [`MXU_ADR_W-1:0]             adr,
    input  logic [31:0]                       dat_w,
    output logic [31:0]                       dat_r,
    output logic                              ack,
    output mxu_pkg::mxu_row_t [`MXU_ROWS-1:0] rows,      // skewed into both tiles
    output mxu_pkg::mxu_vec8_t                w_row,     // weight row for the top cells
    output logic                              w_shift,   // one cycle per weight write
    output logic                              w_clear,
    output logic                              q_flush,
    input  logic [`MXU_CNT_W-1:0]             q_count,
    input  mxu_pkg::mxu_result_t              q_head,
    output logic                              res_pop,   // reading column 3 pops
    input  logic                              done_pulse // a vector reached the queue
);

    mxu_pkg::mxu_wdata_u      wd;        // write word, bytes or command
    logic                     accept;    // ack goes high on this edge
    logic                     wr_acc;
    logic                     rd_acc;
    logic                     act_wr;
    logic                     hold;      // activation write waits for queue room
    logic [`MXU_CNT_W-1:0]    in_flight; // vectors between bus and queue
    logic [`MXU_CNT_W:0]      occupancy;
    logic [`MXU_ADR_W-1:0]    res_off;   // column index when reading results
    logic                     is_res;
    logic [`MXU_ACC_W-1:0]    res_col;
    logic [31:0]              rd_mux;
    logic                     act_v;     // capture stage of an activation vector
    mxu_pkg::mxu_vec8_t       act_q;

    assign wd = dat_w;

    // room check counts both queued results and vectors still in the array
    assign occupancy = {1'b0, in_flight} + {1'b0, q_count};
    assign hold      = we && (adr == `MXU_ADDR_ACT) && (occupancy >= `MXU_Q_DEPTH);

    // the transfer is taken when ack rises, the master may drop stb right after
    assign accept = cyc && stb && !ack && !hold;
    assign wr_acc = accept && we;
    assign rd_acc = accept && !we;
    assign act_wr = wr_acc && (adr == `MXU_ADDR_ACT);

    assign res_off = adr - `MXU_ADDR_RES;      // wraps high below the result base
    assign is_res  = res_off < `MXU_COLS;
    assign res_col = q_head.col[res_off[$clog2(`MXU_COLS)-1:0]];
    assign res_pop = rd_acc && (res_off == `MXU_COLS - 1);

    always_comb begin
        rd_mux = '0; // unmapped and empty reads return zero
        if (adr == `MXU_ADDR_STATUS) begin
            rd_mux = 32'(q_count);
        end else if (is_res && (q_count != '0)) begin
            rd_mux = {{(32 - `MXU_ACC_W){res_col[`MXU_ACC_W-1]}}, res_col}; // sign extend
        end
    end

    // one-cycle ack and the control pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            w_shift <= 1'b0;
            w_clear <= 1'b0;
            q_flush <= 1'b0;
            act_v   <= 1'b0;
        end else begin
            ack     <= accept;
            w_shift <= wr_acc && (adr == `MXU_ADDR_WEIGHT);
            w_clear <= wr_acc && (adr == `MXU_ADDR_CTRL) && wd.ctrl.clear_w;
            q_flush <= wr_acc && (adr == `MXU_ADDR_CTRL) && wd.ctrl.flush_q;
            act_v   <= act_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) dat_r <= rd_mux; // held through the ack cycle
        if (wr_acc && (adr == `MXU_ADDR_WEIGHT)) w_row <= wd.vec;
        if (act_wr) act_q <= wd.vec;
    end

    // credit, up on an accepted vector and down when the collector stores one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            case ({act_wr, done_pulse})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight; // none, or one in and one out
            endcase
        end
    end

    // triangular delay line, row r gets r + 1 stages after the capture register
    for (genvar r = 0; r < `MXU_ROWS; r++) begin : g_skew
        logic [r:0]      v_sr;
        logic [r:0][7:0] d_sr;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                v_sr <= '0;
            end else begin
                v_sr[0] <= act_v;
                for (int k = 1; k <= r; k++) begin
                    v_sr[k] <= v_sr[k-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            d_sr[0] <= act_q.lane[r];
            for (int k = 1; k <= r; k++) begin
                d_sr[k] <= d_sr[k-1];
            end
        end

        assign rows[r].valid = v_sr[r];
        assign rows[r].data  = d_sr[r];
    end

endmodule
